//--- fetchPkg.sv
package fetchPkg;

    localparam int WORD_W      = 16;                  // Instruction word width
    localparam int ADDR_W      = 16;                  // Byte address and PC width
    localparam int MEM_WORDS   = 256;                 // Instruction memory depth
    localparam int MEM_IDX_W   = $clog2(MEM_WORDS);   // Word index, address bits 8 to 1
    localparam int FETCH_STEP  = 2;                   // PC increment per word
    localparam int QUEUE_DEPTH = 2;                   // IF/ID entries
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int LAT_W       = 3;                   // Holds latency values 1 to 4
    localparam int OPC_W       = 5;                   // Opcode field at top of word
    localparam int OFFS_W      = 11;                  // Jump offset field, in words

    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [MEM_IDX_W-1:0]   memIdx_t;
    typedef logic [QUEUE_PTR_W-1:0] qPtr_t;
    typedef logic [QUEUE_CNT_W-1:0] qCnt_t;
    typedef logic [LAT_W-1:0]       latCnt_t;

    // Only these encodings have a meaning, the rest act as ALU ops
    typedef enum logic [OPC_W-1:0] {
        OP_HALT = 5'd0,
        OP_NOP  = 5'd1,
        OP_JUMP = 5'd4,
        OP_ALU  = 5'd8
    } opcode_t;

    typedef struct packed {
        addr_t pc;      // Address the word was read from
        word_t instr;
    } fetchPkt_t;

    typedef struct packed {
        addr_t   pc;
        word_t   instr;
        opcode_t opcode;   // Classified opcode
    } retire_t;

    typedef struct packed {
        logic  taken;   // One-cycle redirect strobe
        addr_t target;
    } redirect_t;

    typedef enum logic {
        DEC_RUN,
        DEC_HALTED
    } decState_t;

    // Read latency is 1 plus address bits 2 to 1
    function automatic latCnt_t readLatency(addr_t addr);
        return latCnt_t'(addr[2:1]) + latCnt_t'(1);
    endfunction

    function automatic opcode_t decodeOp(word_t instr);
        logic [OPC_W-1:0] field;
        field = instr[WORD_W-1 -: OPC_W];
        case (field)
            OP_HALT, OP_NOP, OP_JUMP: return opcode_t'(field);
            default:                  return OP_ALU;   // Unknown retires as plain op
        endcase
    endfunction

    // PC-relative target, offset counted in words from the next PC
    function automatic addr_t jumpTarget(addr_t pc, word_t instr);
        addr_t offs;
        offs = {{(ADDR_W-OFFS_W-1){instr[OFFS_W-1]}}, instr[OFFS_W-1:0], 1'b0};
        return pc + addr_t'(FETCH_STEP) + offs;
    endfunction

endpackage

//--- instrMem.sv
`timescale 1ns/1ps

module instrMem import fetchPkg::*; (
    input  logic  clk,
    input  logic  arstN,
    input  logic  loadEn,     // Program image write strobe
    input  addr_t loadAddr,   // Byte address of loaded word
    input  word_t loadData,
    input  logic  rdEn,       // One-cycle read strobe
    input  addr_t rdAddr,
    output word_t rdData,     // Valid while done is high
    output logic  done,       // Read complete pulse
    output logic  busy        // A read is being served
);

    word_t   mem [MEM_WORDS];   // Program storage
    memIdx_t rdIdx;             // Word index latched at the strobe
    latCnt_t latCnt;            // Cycles left until done
    logic    rdAccept;

    // A strobe during a read is ignored, fetch never does that
    assign rdAccept = rdEn && !busy;

    // Load port, written by the testbench before reset release
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr[MEM_IDX_W:1]] <= loadData;   // Bit 0 ignored
        end
    end

    // Address capture
    always_ff @(posedge clk) begin
        if (rdAccept) begin
            rdIdx <= rdAddr[MEM_IDX_W:1];
        end
    end

    // Latency countdown
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            latCnt <= '0;
        end else if (rdAccept) begin
            latCnt <= readLatency(rdAddr);   // 1 to 4 cycles
        end else if (latCnt != '0) begin
            latCnt <= latCnt - 1'b1;
        end
    end

    // Done in the last counted cycle, so latency 1 answers the next cycle
    assign busy   = (latCnt != '0);
    assign done   = (latCnt == latCnt_t'(1));
    assign rdData = mem[rdIdx];   // Combinational read of latched index

endmodule

//--- fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit import fetchPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    output logic      rdEn,       // Registered read strobe
    output addr_t     rdAddr,
    input  word_t     rdData,
    input  logic      done,
    input  logic      busy,
    input  logic      full,       // IF/ID queue full level
    input  redirect_t redirect,   // Jump from decode
    input  logic      halted,     // Decode has retired a halt
    output logic      push,
    output fetchPkt_t pushPkt,
    output logic      err         // Sticky misaligned target
);

    addr_t     pc;          // Address of current or next read
    logic      discard;     // Outstanding read overtaken by redirect
    logic      holdValid;   // Word parked under back-pressure
    fetchPkt_t holdPkt;
    fetchPkt_t livePkt;     // Word returning this cycle
    logic      liveOk;
    logic      toHold;
    logic      inFlight;
    logic      holdNext;
    logic      errNext;
    logic      issueNext;

    assign livePkt = '{pc: pc, instr: rdData};
    assign rdAddr  = pc;   // PC stays put while the read is out

    // Returned word is usable unless swallowed or misaligned
    assign liveOk = done && !discard && !pc[0];
    assign toHold = liveOk && full && !redirect.taken;   // Park it, queue is full

    // Held word goes first, no read can be out while holding
    assign push    = holdValid ? !full : (liveOk && !full);
    assign pushPkt = holdValid ? holdPkt : livePkt;

    // Strobe cycle or memory still counting
    assign inFlight = rdEn || (busy && !done);

    assign errNext  = err || (redirect.taken && redirect.target[0]);
    assign holdNext = !redirect.taken && (holdValid ? full : toHold);   // Redirect drops it

    // Next strobe only once the memory is free and nothing is parked
    assign issueNext = !inFlight && !holdNext && !halted && !errNext;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc        <= '0;
            rdEn      <= 1'b0;
            discard   <= 1'b0;
            holdValid <= 1'b0;
            err       <= 1'b0;
        end else begin
            rdEn      <= issueNext;
            holdValid <= holdNext;
            err       <= errNext;

            // Redirect wins over the sequential step
            if (redirect.taken) begin
                pc <= redirect.target;
            end else if (liveOk) begin
                pc <= pc + addr_t'(FETCH_STEP);   // Advance once word is pushed or parked
            end

            if (redirect.taken && inFlight) begin
                discard <= 1'b1;   // Swallow the stale done
            end else if (done) begin
                discard <= 1'b0;
            end
        end
    end

    // Back-pressure hold register
    always_ff @(posedge clk) begin
        if (toHold) begin
            holdPkt <= livePkt;
        end
    end

endmodule

//--- ifidQueue.sv
`timescale 1ns/1ps

module ifidQueue import fetchPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  logic      push,
    input  fetchPkt_t pushPkt,
    input  logic      pop,
    input  logic      flush,      // Redirect, drops everything
    output fetchPkt_t headPkt,    // Oldest entry
    output logic      notEmpty,
    output logic      full
);

    fetchPkt_t entries [QUEUE_DEPTH];   // Payload only, no reset
    qPtr_t     wrPtr;
    qPtr_t     rdPtr;
    qCnt_t     count;
    logic      doPush;
    logic      doPop;

    function automatic qPtr_t nextPtr(qPtr_t ptr);
        return (ptr == qPtr_t'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full     = (count == qCnt_t'(QUEUE_DEPTH));
    assign notEmpty = (count != '0);
    assign headPkt  = entries[rdPtr];

    assign doPop  = pop && notEmpty;
    assign doPush = push && (!full || doPop);   // Room freed by a same-cycle pop

    always_ff @(posedge clk) begin
        if (doPush && !flush) begin
            entries[wrPtr] <= pushPkt;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (flush) begin
            wrPtr <= '0;   // Flush beats a push in the same cycle
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

endmodule

//--- decodeStage.sv
`timescale 1ns/1ps

module decodeStage import fetchPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  logic      hold,          // External stall of pops
    input  fetchPkt_t headPkt,
    input  logic      notEmpty,
    output logic      pop,
    output redirect_t redirect,      // Registered, one cycle after the jump pop
    output logic      retireValid,
    output retire_t   retire,
    output logic      halted
);

    decState_t state;
    decState_t stateNext;
    opcode_t   headOp;        // Class of the head word
    addr_t     jumpTgt;
    logic      redirTaken;
    addr_t     redirTarget;
    logic      popJump;
    logic      popHalt;

    assign headOp  = decodeOp(headPkt.instr);
    assign jumpTgt = jumpTarget(headPkt.pc, headPkt.instr);

    // No pop while the queue is being flushed by our own redirect
    assign pop = notEmpty && !hold && (state == DEC_RUN) && !redirTaken;

    assign popJump = pop && (headOp == OP_JUMP);
    assign popHalt = pop && (headOp == OP_HALT);

    always_comb begin
        stateNext = state;
        case (state)
            DEC_RUN: begin
                if (popHalt) begin
                    stateNext = DEC_HALTED;   // Halt word itself still retires
                end
            end
            DEC_HALTED: stateNext = DEC_HALTED;   // Only reset leaves
            default:    stateNext = DEC_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state       <= DEC_RUN;
            retireValid <= 1'b0;
            redirTaken  <= 1'b0;
        end else begin
            state       <= stateNext;
            retireValid <= pop;
            redirTaken  <= popJump;   // One-cycle pulse
        end
    end

    // Retire record and target, payload only
    always_ff @(posedge clk) begin
        if (pop) begin
            retire      <= '{pc: headPkt.pc, instr: headPkt.instr, opcode: headOp};
            redirTarget <= jumpTgt;
        end
    end

    assign redirect = '{taken: redirTaken, target: redirTarget};
    assign halted   = (state == DEC_HALTED);

endmodule

//--- fetchTop.sv
`timescale 1ns/1ps

module fetchTop import fetchPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  logic    loadEn,        // Program load port
    input  addr_t   loadAddr,
    input  word_t   loadData,
    input  logic    hold,          // Stalls decode pops
    output logic    retireValid,
    output retire_t retire,
    output logic    halted,
    output logic    err
);

    logic      rdEn;
    addr_t     rdAddr;
    word_t     rdData;
    logic      done;
    logic      busy;
    logic      push;
    fetchPkt_t pushPkt;
    logic      pop;
    fetchPkt_t headPkt;
    logic      notEmpty;
    logic      full;
    redirect_t redirect;   // Decode to fetch, also flushes the queue

    instrMem uMem (
        .clk      (clk),
        .arstN    (arstN),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .rdEn     (rdEn),
        .rdAddr   (rdAddr),
        .rdData   (rdData),
        .done     (done),
        .busy     (busy)
    );

    fetchUnit uFetch (
        .clk      (clk),
        .arstN    (arstN),
        .rdEn     (rdEn),
        .rdAddr   (rdAddr),
        .rdData   (rdData),
        .done     (done),
        .busy     (busy),
        .full     (full),
        .redirect (redirect),
        .halted   (halted),
        .push     (push),
        .pushPkt  (pushPkt),
        .err      (err)
    );

    ifidQueue uQueue (
        .clk      (clk),
        .arstN    (arstN),
        .push     (push),
        .pushPkt  (pushPkt),
        .pop      (pop),
        .flush    (redirect.taken),
        .headPkt  (headPkt),
        .notEmpty (notEmpty),
        .full     (full)
    );

    decodeStage uDecode (
        .clk         (clk),
        .arstN       (arstN),
        .hold        (hold),
        .headPkt     (headPkt),
        .notEmpty    (notEmpty),
        .pop         (pop),
        .redirect    (redirect),
        .retireValid (retireValid),
        .retire      (retire),
        .halted      (halted)
    );

endmodule

//--- fetchChecker.sv
`timescale 1ns/1ps

module fetchChecker import fetchPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  logic    retireValid,
    input  retire_t retire,
    input  logic    halted,
    input  logic    err,
    input  logic    sectionEnd,   // Current section is finished
    output int      valueErrs,
    output int      otherErrs
);

    typedef struct packed {
        logic [3:0] kind;
        addr_t      addr;
        word_t      data;
    } traceLine_t;

    localparam int TRACE_LEN = 64;

    traceLine_t traceMem [TRACE_LEN];
    int         nValue   = 0;
    int         nOther   = 0;
    int         ptr      = 1;      // Line 0 holds the first section header
    logic       haltSeen = 1'b0;
    logic       errSeen  = 1'b0;

    assign valueErrs = nValue;
    assign otherErrs = nOther;

    initial begin
        $readmemh("fetchTrace.txt", traceMem);
    end

    function automatic logic [3:0] kindAt(int idx);
        if (idx >= TRACE_LEN) begin
            return 4'hF;
        end
        return traceMem[idx].kind;
    endfunction

    // Opcode class from the top five bits
    function automatic opcode_t expectedOp(word_t instr);
        case (instr[15:11])
            5'd0:    return OP_HALT;
            5'd1:    return OP_NOP;
            5'd4:    return OP_JUMP;
            default: return OP_ALU;
        endcase
    endfunction

    task automatic checkRetire();
        traceLine_t want;
        while (kindAt(ptr) === 4'h2) begin
            ptr++;   // Load lines carry no retirement
        end
        if (kindAt(ptr) !== 4'h3) begin
            $display("Extra retirement of pc %h beyond the expected sequence", retire.pc);
            nOther++;
        end else begin
            want = traceMem[ptr];
            if (retire.pc !== want.addr) begin
                $display("FAIL retire.pc: got %h, expected %h", retire.pc, want.addr);
                nValue++;
            end
            if (retire.instr !== want.data) begin
                $display("FAIL retire.instr: got %h, expected %h", retire.instr, want.data);
                nValue++;
            end
            if (retire.opcode !== expectedOp(want.data)) begin
                $display("FAIL retire.opcode: got %h, expected %h",
                         retire.opcode, expectedOp(want.data));
                nValue++;
            end
            ptr++;
        end
    endtask

    task automatic closeSection();
        while (kindAt(ptr) === 4'h2 || kindAt(ptr) === 4'h3) begin
            if (kindAt(ptr) === 4'h3) begin
                $display("Missing retirement, pc %h never retired", traceMem[ptr].addr);
                nOther++;
            end
            ptr++;
        end
        if (!haltSeen) begin
            $display("Section ended without halted going high");
            nOther++;
        end
        ptr++;   // Step over the next header
    endtask

    // Negedge sampling, DUT outputs settle after the rising edge
    always @(negedge clk) begin
        if (!arstN) begin
            haltSeen = 1'b0;
            errSeen  = 1'b0;
        end else begin
            if (retireValid) begin
                checkRetire();
            end
            if (haltSeen && !halted) begin
                $display("halted dropped after a halt had retired");
                nOther++;
            end
            if (err && !errSeen) begin
                $display("err went high on a program with only even jump targets");
                nOther++;
            end
            haltSeen = haltSeen || halted;
            errSeen  = errSeen || err;
        end
        if (sectionEnd) begin
            closeSection();
        end
    end

endmodule

//--- fetchTb.sv
`timescale 1ns/1ps

module fetchTb import fetchPkg::*; ();

    typedef struct packed {
        logic [3:0] kind;   // 1 section, 2 load, 3 expect, F end
        addr_t      addr;
        word_t      data;
    } traceLine_t;

    localparam int TRACE_LEN    = 64;
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_CYCLES = 8;    // Room for a late or extra retirement
    localparam int FILL_CYCLES  = 12;   // Queue fills and one word parks in fetch

    traceLine_t traceMem [TRACE_LEN];
    logic       clk;
    logic       arstN;
    logic       loadEn;
    addr_t      loadAddr;
    word_t      loadData;
    logic       hold;
    logic       retireValid;
    retire_t    retire;
    logic       halted;
    logic       err;
    logic       sectionEnd;   // Tells the checker a section is over
    int         valueErrs;
    int         otherErrs;
    int         setupErrs;
    int         seed;
    int         limitCycles;
    int         lineIdx;

    fetchTop UUT (.*);

    fetchChecker uCheck (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [3:0] kindAt(int idx);
        if (idx >= TRACE_LEN) begin
            return 4'hF;
        end
        return traceMem[idx].kind;
    endfunction

    // One section runs reset, program load, run to halt and drain
    task automatic runSection(inout int idx);
        logic holdMode;
        int   rnd;
        int   runCycles;
        holdMode = traceMem[idx].data[0];
        idx++;
        @(posedge clk);
        #1;
        arstN = 1'b0;
        hold  = 1'b0;
        while (kindAt(idx) === 4'h2 || kindAt(idx) === 4'h3) begin
            if (kindAt(idx) === 4'h2) begin
                loadEn   = 1'b1;   // Image goes in while the DUT sits in reset
                loadAddr = traceMem[idx].addr;
                loadData = traceMem[idx].data;
                @(posedge clk);
                #1;
            end
            idx++;
        end
        loadEn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arstN     = 1'b1;
        runCycles = 0;
        while (!halted && !err) begin
            rnd  = $random(seed);
            // Solid stall first so back-pressure is reached, then about half the cycles
            hold = holdMode && (runCycles < FILL_CYCLES || rnd[0]);
            runCycles++;
            @(posedge clk);
            #1;
        end
        hold = 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clk);
        #1;
        sectionEnd = 1'b1;
        @(posedge clk);
        #1;
        sectionEnd = 1'b0;
    endtask

    initial begin
        int expCount;
        arstN       = 1'b0;
        loadEn      = 1'b0;
        loadAddr    = '0;
        loadData    = '0;
        hold        = 1'b0;
        sectionEnd  = 1'b0;
        seed        = 15907;
        setupErrs   = 0;
        expCount    = 0;
        limitCycles = 0;
        lineIdx     = 0;
        $readmemh("fetchTrace.txt", traceMem);
        for (int i = 0; i < TRACE_LEN; i++) begin
            if (traceMem[i].kind === 4'h3) begin
                expCount++;
            end
        end
        if (expCount == 0) begin
            $display("No expected retirements found in fetchTrace.txt");
            setupErrs++;
        end else begin
            limitCycles = 100 * expCount;
            while (kindAt(lineIdx) === 4'h1) begin
                runSection(lineIdx);
            end
        end
        $display("Errors: %0d value, %0d sequence or state, %0d setup",
                 valueErrs, otherErrs, setupErrs);
        if (valueErrs + otherErrs + setupErrs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog scaled by the number of expected retirements
    initial begin
        wait (limitCycles > 0);
        repeat (limitCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the run ended", limitCycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- fetchTrace.txt
// Columns: kind_addr_data in hex; kind 1 opens a section, data bit 0 turns on random hold
// Kind 2 loads data at addr, kind 3 expects pc addr to retire with instr data, F ends the file
// Straight-line words over all four latencies, jumps forward and back, then halt
1_0000_0000
2_0000_4001
2_0002_0800
2_0004_F855
2_0006_2003
2_0008_4888
2_000E_2002
2_0010_4010
2_0012_0000
2_0014_27FD
3_0000_4001
3_0002_0800
3_0004_F855
3_0006_2003
3_000E_2002
3_0014_27FD
3_0010_4010
3_0012_0000
// Same image again with random hold on decode, retire order unchanged
1_0000_0001
3_0000_4001
3_0002_0800
3_0004_F855
3_0006_2003
3_000E_2002
3_0014_27FD
3_0010_4010
3_0012_0000
F_0000_0000

//--- build.f
fetchPkg.sv
instrMem.sv
fetchUnit.sv
ifidQueue.sv
decodeStage.sv
fetchTop.sv
fetchChecker.sv
fetchTb.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing -f build.f --top-module fetchTb -Mdir obj_dir -o fetchSim

run: compile
	./obj_dir/fetchSim | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
